// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_fdc_top
FILELIST  = fdc_top.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: fdc_top.f
+incdir+test
src/fdc_pkg.sv
src/fdc_regs.sv
src/fdc_cmd_fsm.sv
src/fdc_timer.sv
src/fdc_geometry.sv
src/fdc_top.sv
test/tb_fdc_top.sv

// File: src/fdc_cmd_fsm.sv
/*
 * fdc_cmd_fsm
 * Command sequencer. Runs type I head commands, single and multi-sector
 * reads and force interrupt. Owns the physical head position, the step
 * direction and the status flags for both status modes.
 */
`timescale 1ns/1ps

module fdc_cmd_fsm
	import fdc_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  cmd_strobe,
	input  logic [7:0]            cmd_byte,
	input  logic                  data_taken,
	input  logic                  status_taken,
	input  logic                  ready,
	input  logic [7:0]            data_reg,
	input  logic                  sector_valid,
	input  logic [SECT_LEN_W-1:0] sector_len,
	input  logic                  delay_done,
	input  logic                  watchdog_bark,
	output logic                  busy,
	output logic                  drq,
	output logic                  intrq,
	output logic                  reading,
	output logic [7:0]            status_byte,
	output logic                  sector_inc,
	output logic                  track_load,
	output logic [7:0]            track_value,
	output logic [7:0]            head_track,
	output logic [SECT_LEN_W-1:0] byte_index,
	output logic                  delay_start,
	output fdc_delay_e            delay_sel,
	output logic                  wd_restart
);

	fdc_state_e  state;
	fdc_opcode_e opcode;
	logic        cmd_mode;   // 0 type I layout, 1 read layout
	logic        step_dir;   // 1 = outward
	logic        multi;
	logic        seek_err;
	logic        lost_data;
	logic        step_out;
	logic        last_byte;
	logic [7:0]  next_track;

	assign opcode = fdc_opcode_e'(cmd_byte[7:4]);

	// plain step keeps the last direction
	assign step_out = cmd_byte[6] ? cmd_byte[5] : step_dir;
	assign next_track = step_out ? ((head_track == 8'd0) ? 8'd0 : head_track - 8'd1)
		: head_track + 8'd1;
	assign last_byte = (byte_index == sector_len - 1'b1);

	// bit 5 reads 1 since the core never writes
	assign status_byte = cmd_mode
		? {~ready, 1'b0, 1'b1, seek_err | ~ready, 1'b0, lost_data, drq, busy}
		: {~ready, 1'b0, 1'b1, seek_err | ~ready, 1'b0, head_track == 8'd0, 1'b0, busy};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state       <= ST_IDLE;
			cmd_mode    <= 1'b0;
			step_dir    <= 1'b0;
			multi       <= 1'b0;
			seek_err    <= 1'b0;
			lost_data   <= 1'b0;
			busy        <= 1'b0;
			drq         <= 1'b0;
			intrq       <= 1'b0;
			reading     <= 1'b0;
			sector_inc  <= 1'b0;
			track_load  <= 1'b0;
			track_value <= 8'd0;
			head_track  <= 8'd0;
			byte_index  <= '0;
			delay_start <= 1'b0;
			delay_sel   <= DLY_SEEK;
			wd_restart  <= 1'b0;
		end else begin
			sector_inc  <= 1'b0;
			track_load  <= 1'b0;
			delay_start <= 1'b0;
			wd_restart  <= 1'b0;

			if (status_taken)
				intrq <= 1'b0;

			// ====================
			// sequencing
			case (state)
				ST_IDLE: ;
				ST_SEARCH: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state    <= ST_END;
					end else if (delay_done) begin
						if (!sector_valid) begin
							seek_err <= 1'b1; // no such sector on this track
							state    <= ST_END;
						end else begin
							delay_start <= 1'b1;
							delay_sel   <= DLY_BYTE;
							wd_restart  <= 1'b1;
							state       <= ST_BYTE_WAIT;
						end
					end
				end
				ST_BYTE_WAIT: begin
					if (delay_done) begin
						drq   <= 1'b1;
						state <= ST_BYTE_DRQ;
					end
				end
				ST_BYTE_DRQ: begin
					if (watchdog_bark || data_taken) begin
						drq <= 1'b0;
						if (watchdog_bark && !data_taken)
							lost_data <= 1'b1; // byte skipped
						if (!last_byte) begin
							byte_index  <= byte_index + 1'b1;
							delay_start <= 1'b1;
							delay_sel   <= DLY_BYTE;
							wd_restart  <= 1'b1;
							state       <= ST_BYTE_WAIT;
						end else if (multi) begin
							sector_inc  <= 1'b1;
							byte_index  <= '0;
							delay_start <= 1'b1;
							delay_sel   <= DLY_SEEK;
							state       <= ST_SEARCH;
						end else begin
							state <= ST_END;
						end
					end
				end
				ST_BUSY_WAIT: begin
					if (delay_done)
						state <= ST_END;
				end
				ST_ABORT: begin
					seek_err  <= 1'b0;
					lost_data <= 1'b0;
					state     <= ST_END;
				end
				ST_END: begin
					busy    <= 1'b0;
					drq     <= 1'b0;
					reading <= 1'b0;
					intrq   <= 1'b1;
					state   <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase

			// ====================
			// command decode
			if (cmd_strobe) begin
				intrq <= 1'b0;
				if (opcode == OP_FORCE_INT) begin
					cmd_mode <= 1'b0;
					if (state != ST_IDLE) begin
						state <= ST_ABORT;
					end else begin
						seek_err  <= 1'b0;
						lost_data <= 1'b0;
						busy      <= 1'b0;
						drq       <= 1'b0;
					end
				end else if (state == ST_IDLE) begin
					if (!cmd_byte[7]) begin // type I
						cmd_mode    <= 1'b0;
						seek_err    <= 1'b0;
						busy        <= 1'b1;
						delay_start <= 1'b1;
						delay_sel   <= DLY_BUSY;
						state       <= ST_BUSY_WAIT;
					end
					case (opcode)
						OP_RESTORE: begin
							head_track  <= 8'd0;
							track_value <= 8'd0;
							track_load  <= 1'b1;
						end
						OP_SEEK: begin
							head_track  <= data_reg;
							track_value <= data_reg;
							track_load  <= 1'b1;
						end
						OP_STEP, OP_STEP_U, OP_STEP_IN, OP_STEP_IN_U,
						OP_STEP_OUT, OP_STEP_OUT_U: begin
							if (cmd_byte[6])
								step_dir <= cmd_byte[5];
							head_track  <= next_track;
							track_value <= next_track;
							track_load  <= cmd_byte[4]; // update flag
						end
						OP_READ, OP_READ_M: begin
							cmd_mode    <= 1'b1;
							seek_err    <= 1'b0;
							lost_data   <= 1'b0;
							busy        <= 1'b1;
							reading     <= 1'b1;
							multi       <= (opcode == OP_READ_M);
							byte_index  <= '0;
							delay_start <= 1'b1;
							delay_sel   <= DLY_SEEK;
							state       <= ST_SEARCH;
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: src/fdc_geometry.sv
/*
 * fdc_geometry
 * Sector geometry from size_code and the image byte address for the
 * current head track, side, sector and byte. Layout is track-side-sector.
 */
`timescale 1ns/1ps

module fdc_geometry
	import fdc_pkg::*;
(
	input  logic [2:0]            size_code,
	input  logic                  side,
	input  logic [7:0]            head_track,
	input  logic [7:0]            sector_reg,
	input  logic [SECT_LEN_W-1:0] byte_index,
	output logic [IMG_ADDR_W-1:0] buff_addr,
	output logic                  sector_valid,
	output logic [SECT_LEN_W-1:0] sector_len
);

	logic [4:0]            spt;      // sectors per track
	logic [1:0]            size_sh;  // sector size as 128 << size_sh
	logic [14:0]           sect_num; // linear sector number in image
	logic [IMG_ADDR_W-1:0] sect_base;

	always_comb begin
		case (size_code)
			3'd0: begin spt = 5'd26; size_sh = 2'd0; end
			3'd1: begin spt = 5'd16; size_sh = 2'd1; end
			3'd2: begin spt = 5'd9;  size_sh = 2'd2; end
			3'd3: begin spt = 5'd5;  size_sh = 2'd3; end
			3'd4: begin spt = 5'd10; size_sh = 2'd2; end
			default: begin
				spt     = 5'd0; // no valid sector
				size_sh = 2'd0;
			end
		endcase
	end

	assign sector_len = SECT_LEN_W'(128) << size_sh;
	assign sector_valid = (sector_reg != 8'd0) && (sector_reg <= {3'b000, spt});

	// ((track*2 + side) * spt + sector - 1) * size + byte
	assign sect_num  = 15'({head_track, side}) * 15'(spt) + 15'(sector_reg) - 15'd1;
	assign sect_base = IMG_ADDR_W'(sect_num) << (4'd7 + 4'(size_sh));
	assign buff_addr = sect_base + IMG_ADDR_W'(byte_index);

endmodule

// File: src/fdc_pkg.sv
/*
 * fdc_pkg
 * Shared definitions for the WD1793-style floppy controller core:
 * host register addresses, command opcodes, FSM states, delay
 * selectors, timing counts and image geometry widths.
 */
package fdc_pkg;

	// host register map, 2-bit address
	typedef enum logic [1:0] {
		A_CMD_STATUS = 2'd0,
		A_TRACK      = 2'd1,
		A_SECTOR     = 2'd2,
		A_DATA       = 2'd3
	} fdc_reg_addr_e;

	// upper nibble of the command byte
	typedef enum logic [3:0] {
		OP_RESTORE    = 4'h0,
		OP_SEEK       = 4'h1,
		OP_STEP       = 4'h2,
		OP_STEP_U     = 4'h3,
		OP_STEP_IN    = 4'h4,
		OP_STEP_IN_U  = 4'h5,
		OP_STEP_OUT   = 4'h6,
		OP_STEP_OUT_U = 4'h7,
		OP_READ       = 4'h8,
		OP_READ_M     = 4'h9,
		OP_FORCE_INT  = 4'hD
	} fdc_opcode_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SEARCH,
		ST_BYTE_WAIT,
		ST_BYTE_DRQ,
		ST_BUSY_WAIT,
		ST_ABORT,
		ST_END
	} fdc_state_e;

	typedef enum logic [1:0] {
		DLY_SEEK,
		DLY_BYTE,
		DLY_BUSY
	} fdc_delay_e;

	// ====================
	// timing, in clk_sys cycles
	localparam int unsigned SEEK_CYCLES     = 1023; // settle before sector search
	localparam int unsigned BYTE_CYCLES     = 16;   // gap before each DRQ
	localparam int unsigned BUSY_CYCLES     = 4000; // type I busy time
	localparam int unsigned WATCHDOG_CYCLES = 4096; // DRQ time before lost data
	localparam int unsigned DLY_CNT_W       = 12;   // fits the longest delay
	localparam int unsigned WD_CNT_W        = 13;

	// ====================
	// image geometry
	localparam int unsigned IMG_ADDR_W = 20; // up to 1 MB image
	localparam int unsigned SECT_LEN_W = 11; // up to 1024 bytes per sector

endpackage

// File: src/fdc_regs.sv
/*
 * fdc_regs
 * Host bus side. Edge detection on rd and wr, track, sector and data
 * registers, command strobe to the FSM and the read-data mux.
 */
`timescale 1ns/1ps

module fdc_regs
	import fdc_pkg::*;
(
	input  logic          clk_sys,
	input  logic          rst,
	input  logic          rd,
	input  logic          wr,
	input  fdc_reg_addr_e addr,
	input  logic [7:0]    din,
	input  logic          busy,
	input  logic          reading,
	input  logic [7:0]    status_byte,
	input  logic [7:0]    buff_din,
	input  logic          sector_inc,
	input  logic          track_load,
	input  logic [7:0]    track_value,
	output logic [7:0]    dout,
	output logic          buff_read,
	output logic          cmd_strobe,
	output logic [7:0]    cmd_byte,
	output logic          data_taken,
	output logic          status_taken,
	output logic [7:0]    track_reg,
	output logic [7:0]    sector_reg,
	output logic [7:0]    data_reg
);

	logic          rd_q;
	logic          wr_q;
	logic          wr_act;   // write acts one cycle after the edge
	logic [7:0]    wr_data;
	fdc_reg_addr_e cur_addr;

	// falling edge of rd ends a register read
	assign data_taken   = rd_q && !rd && (cur_addr == A_DATA);
	assign status_taken = rd_q && !rd && (cur_addr == A_CMD_STATUS);
	assign buff_read    = reading && (addr == A_DATA);

	always_comb begin
		case (addr)
			A_CMD_STATUS: dout = status_byte;
			A_TRACK:      dout = track_reg;
			A_SECTOR:     dout = sector_reg;
			default:      dout = reading ? buff_din : data_reg;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (wr && !wr_q)
			wr_data <= din;
		if (wr_act && cur_addr == A_CMD_STATUS)
			cmd_byte <= wr_data;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rd_q       <= 1'b0;
			wr_q       <= 1'b0;
			wr_act     <= 1'b0;
			cmd_strobe <= 1'b0;
			cur_addr   <= A_CMD_STATUS;
			track_reg  <= 8'd0;
			sector_reg <= 8'd0;
			data_reg   <= 8'd0;
		end else begin
			rd_q       <= rd;
			wr_q       <= wr;
			wr_act     <= wr && !wr_q;
			cmd_strobe <= wr_act && (cur_addr == A_CMD_STATUS);
			if ((rd && !rd_q) || (wr && !wr_q))
				cur_addr <= addr;

			if (wr_act) begin
				case (cur_addr)
					A_TRACK:  if (!busy) track_reg <= wr_data;
					A_SECTOR: if (!busy) sector_reg <= wr_data;
					A_DATA:   data_reg <= wr_data;
					default: ;
				endcase
			end

			if (sector_inc)
				sector_reg <= sector_reg + 8'd1; // multi-sector advance
			if (track_load)
				track_reg <= track_value;
		end
	end

endmodule

// File: src/fdc_timer.sv
/*
 * fdc_timer
 * Delay counter for seek settle, byte gap and type I busy time,
 * plus the DRQ lost-data watchdog.
 */
`timescale 1ns/1ps

module fdc_timer
	import fdc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       delay_start,
	input  fdc_delay_e delay_sel,
	input  logic       wd_restart,
	output logic       delay_done,
	output logic       watchdog_bark
);

	logic [DLY_CNT_W-1:0] dly_cnt;
	logic [DLY_CNT_W-1:0] dly_load;
	logic                 dly_active;
	logic [WD_CNT_W-1:0]  wd_cnt;

	always_comb begin
		case (delay_sel)
			DLY_SEEK: dly_load = DLY_CNT_W'(SEEK_CYCLES - 1);
			DLY_BYTE: dly_load = DLY_CNT_W'(BYTE_CYCLES - 1);
			default:  dly_load = DLY_CNT_W'(BUSY_CYCLES - 1);
		endcase
	end

	assign delay_done    = dly_active && (dly_cnt == '0);
	assign watchdog_bark = (wd_cnt == '0); // idles expired

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dly_active <= 1'b0;
			dly_cnt    <= '0;
			wd_cnt     <= '0;
		end else begin
			if (delay_start) begin
				dly_cnt    <= dly_load;
				dly_active <= 1'b1;
			end else if (dly_active) begin
				if (dly_cnt == '0)
					dly_active <= 1'b0; // done shown for one cycle
				else
					dly_cnt <= dly_cnt - 1'b1;
			end

			if (wd_restart)
				wd_cnt <= WD_CNT_W'(WATCHDOG_CYCLES);
			else if (wd_cnt != '0)
				wd_cnt <= wd_cnt - 1'b1;
		end
	end

endmodule

// File: src/fdc_top.sv
/*
 * fdc_top
 * Floppy disk controller core following the WD1793 register model.
 * Type I head commands, single and multi-sector read from an external
 * image RAM, and force interrupt.
 */
`timescale 1ns/1ps

module fdc_top
	import fdc_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  rd,
	input  logic                  wr,
	input  fdc_reg_addr_e         addr,
	input  logic [7:0]            din,
	output logic [7:0]            dout,
	output logic                  drq,
	output logic                  intrq,
	output logic                  busy,
	input  logic [2:0]            size_code,
	input  logic                  side,
	input  logic                  ready,
	output logic [IMG_ADDR_W-1:0] buff_addr,
	output logic                  buff_read,
	input  logic [7:0]            buff_din
);

	logic                  reading;
	logic [7:0]            status_byte;
	logic                  sector_inc;
	logic                  track_load;
	logic [7:0]            track_value;
	logic                  cmd_strobe;
	logic [7:0]            cmd_byte;
	logic                  data_taken;
	logic                  status_taken;
	logic [7:0]            track_reg;
	logic [7:0]            sector_reg;
	logic [7:0]            data_reg;
	logic [7:0]            head_track;
	logic [SECT_LEN_W-1:0] byte_index;
	logic [SECT_LEN_W-1:0] sector_len;
	logic                  sector_valid;
	logic                  delay_start;
	fdc_delay_e            delay_sel;
	logic                  delay_done;
	logic                  wd_restart;
	logic                  watchdog_bark;

	fdc_regs u_regs (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.rd           (rd),
		.wr           (wr),
		.addr         (addr),
		.din          (din),
		.busy         (busy),
		.reading      (reading),
		.status_byte  (status_byte),
		.buff_din     (buff_din),
		.sector_inc   (sector_inc),
		.track_load   (track_load),
		.track_value  (track_value),
		.dout         (dout),
		.buff_read    (buff_read),
		.cmd_strobe   (cmd_strobe),
		.cmd_byte     (cmd_byte),
		.data_taken   (data_taken),
		.status_taken (status_taken),
		.track_reg    (track_reg),
		.sector_reg   (sector_reg),
		.data_reg     (data_reg)
	);

	fdc_cmd_fsm u_fsm (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.cmd_strobe    (cmd_strobe),
		.cmd_byte      (cmd_byte),
		.data_taken    (data_taken),
		.status_taken  (status_taken),
		.ready         (ready),
		.data_reg      (data_reg),
		.sector_valid  (sector_valid),
		.sector_len    (sector_len),
		.delay_done    (delay_done),
		.watchdog_bark (watchdog_bark),
		.busy          (busy),
		.drq           (drq),
		.intrq         (intrq),
		.reading       (reading),
		.status_byte   (status_byte),
		.sector_inc    (sector_inc),
		.track_load    (track_load),
		.track_value   (track_value),
		.head_track    (head_track),
		.byte_index    (byte_index),
		.delay_start   (delay_start),
		.delay_sel     (delay_sel),
		.wd_restart    (wd_restart)
	);

	fdc_timer u_timer (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.delay_start   (delay_start),
		.delay_sel     (delay_sel),
		.wd_restart    (wd_restart),
		.delay_done    (delay_done),
		.watchdog_bark (watchdog_bark)
	);

	fdc_geometry u_geometry (
		.size_code    (size_code),
		.side         (side),
		.head_track   (head_track),
		.sector_reg   (sector_reg),
		.byte_index   (byte_index),
		.buff_addr    (buff_addr),
		.sector_valid (sector_valid),
		.sector_len   (sector_len)
	);

endmodule

// File: test/tb_fdc_tasks.svh
/*
 * testbench helpers for the floppy controller
 * host bus access, bounded waits on drq and intrq, compare tasks
 * and the xorshift generator behind the image RAM model
 */
`ifndef TB_FDC_TASKS_SVH
`define TB_FDC_TASKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// ====================
// host bus
task automatic write_reg(input fdc_reg_addr_e a, input logic [7:0] d);
	@(posedge clk_sys);
	#1;
	addr = a;
	din  = d;
	wr   = 1'b1;
	@(posedge clk_sys);
	#1;
	wr = 1'b0;
	repeat (3) @(posedge clk_sys); // strobe has reached the FSM
	#1;
endtask

task automatic read_reg(input fdc_reg_addr_e a, output logic [7:0] d);
	@(posedge clk_sys);
	#1;
	addr = a;
	rd   = 1'b1;
	@(posedge clk_sys);
	#1;
	d  = dout;
	rd = 1'b0;
	@(posedge clk_sys); // falling edge of rd seen here
	#1;
endtask

// ====================
// waits, each bounded by its own limit
task automatic wait_drq(input int limit, output bit ok);
	ok = 1'b0;
	for (int n = 0; n < limit; n++) begin
		@(posedge clk_sys);
		#1;
		if (drq) begin
			ok = 1'b1;
			break;
		end
	end
	if (!ok) begin
		timeout_errors++;
		$display("timeout: drq did not rise within %0d cycles", limit);
	end
endtask

task automatic wait_drq_low(input int limit, output bit ok);
	ok = 1'b0;
	for (int n = 0; n < limit; n++) begin
		@(posedge clk_sys);
		#1;
		if (!drq) begin
			ok = 1'b1;
			break;
		end
	end
	if (!ok) begin
		timeout_errors++;
		$display("timeout: drq was never dropped by the watchdog (%0d cycles)", limit);
	end
endtask

task automatic wait_intrq(input int limit, output bit ok);
	ok = 1'b0;
	for (int n = 0; n < limit; n++) begin
		@(posedge clk_sys);
		#1;
		if (intrq) begin
			ok = 1'b1;
			break;
		end
	end
	if (!ok) begin
		timeout_errors++;
		$display("timeout: command did not end with intrq within %0d cycles", limit);
	end
endtask

// ====================
// compare
task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		value_errors++;
		$display("error: %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		value_errors++;
		$display("error: %s got %h expected %h", name, got, exp);
	end
endtask

`endif

// File: test/tb_fdc_top.sv
/*
 * tb_fdc_top
 * Directed testbench for the floppy controller core. Drives the host
 * register bus, models the image RAM and checks type I commands,
 * sector reads, lost data and force interrupt.
 */
`timescale 1ns/1ps

module tb_fdc_top
	import fdc_pkg::*;
();

	localparam logic [31:0] SEED = 32'h6635_1c06;

	logic                  clk_sys;
	logic                  rst;
	logic                  rd;
	logic                  wr;
	fdc_reg_addr_e         addr;
	logic [7:0]            din;
	logic [7:0]            dout;
	logic                  drq;
	logic                  intrq;
	logic                  busy;
	logic [2:0]            size_code;
	logic                  side;
	logic                  ready;
	logic [IMG_ADDR_W-1:0] buff_addr;
	logic                  buff_read;
	logic [7:0]            buff_din;
	int                    value_errors;
	int                    timeout_errors;

	// geometry by size_code
	int spt_tab [5] = '{26, 16, 9, 5, 10};
	int len_tab [5] = '{128, 256, 512, 1024, 512};

	`include "tb_fdc_tasks.svh"

	fdc_top fdc_top_inst (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.rd        (rd),
		.wr        (wr),
		.addr      (addr),
		.din       (din),
		.dout      (dout),
		.drq       (drq),
		.intrq     (intrq),
		.busy      (busy),
		.size_code (size_code),
		.side      (side),
		.ready     (ready),
		.buff_addr (buff_addr),
		.buff_read (buff_read),
		.buff_din  (buff_din)
	);

	// ====================
	// image RAM model
	function automatic logic [7:0] ram_byte(input logic [IMG_ADDR_W-1:0] a);
		logic [31:0] r;
		r = xorshift32(32'(a) ^ SEED);
		return r[7:0];
	endfunction

	assign buff_din = ram_byte(buff_addr);

	// track-side-sector layout
	function automatic int image_addr(input int sz, input int trk, input int sd,
		input int sec, input int idx);
		return ((trk * 2 + sd) * spt_tab[sz] + sec - 1) * len_tab[sz] + idx;
	endfunction

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// reads count sectors and compares every byte with the image model
	task automatic read_sectors(input int sz, input int trk, input int sd,
		input int first, input int count);
		logic [7:0] v;
		bit         ok;
		for (int s = first; s < first + count; s++) begin
			for (int i = 0; i < len_tab[sz]; i++) begin
				wait_drq(SEEK_CYCLES + BYTE_CYCLES + 100, ok);
				if (!ok)
					return;
				read_reg(A_DATA, v);
				check_byte("dout", v, ram_byte(IMG_ADDR_W'(image_addr(sz, trk, sd, s, i))));
				check_flag("buff_read", buff_read, 1'b1);
			end
		end
	endtask

	task automatic run_type1(input logic [7:0] cmd, input logic [7:0] exp_track,
		input logic [7:0] exp_status);
		logic [7:0] v;
		bit         ok;
		write_reg(A_CMD_STATUS, cmd);
		check_flag("busy", busy, 1'b1);
		wait_intrq(BUSY_CYCLES + 100, ok);
		check_flag("busy", busy, 1'b0); // falls with intrq
		read_reg(A_TRACK, v);
		check_byte("track", v, exp_track);
		read_reg(A_CMD_STATUS, v);
		check_byte("status", v, exp_status);
		check_flag("intrq", intrq, 1'b0);
	endtask

	// ====================
	// directed tests
	task automatic test_reset();
		logic [7:0] v;
		check_flag("busy", busy, 1'b0);
		check_flag("drq", drq, 1'b0);
		check_flag("intrq", intrq, 1'b0);
		check_byte("dout", dout, 8'h24);
		read_reg(A_CMD_STATUS, v);
		check_byte("status", v, 8'h24);
		read_reg(A_TRACK, v);
		check_byte("track", v, 8'h00);
		read_reg(A_SECTOR, v);
		check_byte("sector", v, 8'h00);
	endtask

	task automatic test_registers();
		logic [7:0] v;
		write_reg(A_TRACK, 8'h5a);
		write_reg(A_SECTOR, 8'ha3);
		write_reg(A_DATA, 8'd40);
		read_reg(A_TRACK, v);
		check_byte("track", v, 8'h5a);
		read_reg(A_SECTOR, v);
		check_byte("sector", v, 8'ha3);
		read_reg(A_DATA, v);
		check_byte("data", v, 8'd40);
	endtask

	task automatic test_type1();
		run_type1(8'h10, 8'd40, 8'h20); // seek to data register
		run_type1(8'h50, 8'd41, 8'h20); // step-in, update
		run_type1(8'h60, 8'd41, 8'h20); // step-out, track reg kept
		run_type1(8'h00, 8'd0, 8'h24);
	endtask

	task automatic test_single_read();
		logic [7:0] v;
		bit         ok;
		write_reg(A_DATA, 8'd5);
		run_type1(8'h10, 8'd5, 8'h20);
		size_code = 3'd1;
		side      = 1'b1;
		write_reg(A_SECTOR, 8'd3);
		write_reg(A_CMD_STATUS, 8'h80);
		read_sectors(1, 5, 1, 3, 1);
		wait_intrq(SEEK_CYCLES + 100, ok);
		check_flag("busy", busy, 1'b0);
		check_flag("buff_read", buff_read, 1'b0); // command over, addr still data
		read_reg(A_CMD_STATUS, v);
		check_byte("status", v, 8'h20);
	endtask

	task automatic test_multi_read();
		logic [7:0] v;
		bit         ok;
		size_code = 3'd3;
		side      = 1'b0;
		write_reg(A_SECTOR, 8'd4);
		write_reg(A_CMD_STATUS, 8'h90);
		read_sectors(3, 5, 0, 4, 2);
		wait_intrq(SEEK_CYCLES + 100, ok);
		read_reg(A_CMD_STATUS, v);
		check_byte("status", v, 8'h30); // ran off the track
		read_reg(A_SECTOR, v);
		check_byte("sector", v, 8'd6);

		write_reg(A_SECTOR, 8'd0);
		write_reg(A_CMD_STATUS, 8'h80);
		wait_intrq(SEEK_CYCLES + 100, ok);
		check_flag("drq", drq, 1'b0);
		read_reg(A_CMD_STATUS, v);
		check_byte("status", v, 8'h30);

		ready = 1'b0;
		write_reg(A_SECTOR, 8'd1);
		write_reg(A_CMD_STATUS, 8'h80);
		wait_intrq(SEEK_CYCLES + 100, ok);
		read_reg(A_CMD_STATUS, v);
		check_byte("status", v, 8'hb0);
		ready = 1'b1;
	endtask

	task automatic test_lost_data();
		logic [7:0] v;
		bit         ok;
		size_code = 3'd1;
		write_reg(A_SECTOR, 8'd1);
		write_reg(A_CMD_STATUS, 8'h80);
		wait_drq(SEEK_CYCLES + BYTE_CYCLES + 100, ok);
		read_reg(A_DATA, v);
		check_byte("dout", v, ram_byte(IMG_ADDR_W'(image_addr(1, 5, 0, 1, 0))));
		wait_drq(BYTE_CYCLES + 100, ok); // byte 1 left unread
		wait_drq_low(WATCHDOG_CYCLES + 100, ok);
		wait_drq(BYTE_CYCLES + 100, ok);
		read_reg(A_DATA, v);
		check_byte("dout", v, ram_byte(IMG_ADDR_W'(image_addr(1, 5, 0, 1, 2))));
		read_reg(A_CMD_STATUS, v);
		check_flag("status lost data", v[2], 1'b1);
		check_flag("status busy", v[0], 1'b1);

		write_reg(A_CMD_STATUS, 8'hd0);
		wait_intrq(8, ok);
		check_flag("busy", busy, 1'b0);
		check_flag("drq", drq, 1'b0);
		read_reg(A_CMD_STATUS, v);
		check_byte("status", v, 8'h20); // flags cleared by the abort
		check_flag("intrq", intrq, 1'b0);
	endtask

	initial begin
		rst            = 1'b1;
		rd             = 1'b0;
		wr             = 1'b0;
		addr           = A_CMD_STATUS;
		din            = 8'h00;
		size_code      = 3'd1;
		side           = 1'b0;
		ready          = 1'b1;
		value_errors   = 0;
		timeout_errors = 0;
		repeat (16) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		test_reset();
		test_registers();
		test_type1();
		test_single_read();
		test_multi_read();
		test_lost_data();

		$display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
